// ==== src/opn2_consts.svh ====
`ifndef OPN2_CONSTS_SVH
`define OPN2_CONSTS_SVH

// Register map, part I only
`define OPN2_REG_TIMER_A_HI   8'h24  // Timer A value, bits 9..2
`define OPN2_REG_TIMER_A_LO   8'h25  // Timer A value, bits 1..0
`define OPN2_REG_TIMER_B      8'h26
`define OPN2_REG_TIMER_CTRL   8'h27
`define OPN2_REG_DAC_DATA     8'h2A
`define OPN2_REG_DAC_EN       8'h2B
`define OPN2_REG_CH6_PAN      8'hB6

// Bits of the timer control register
`define OPN2_CTRL_LOAD_A      0
`define OPN2_CTRL_LOAD_B      1
`define OPN2_CTRL_EN_A        2
`define OPN2_CTRL_EN_B        3
`define OPN2_CTRL_RST_A       4
`define OPN2_CTRL_RST_B       5

`define OPN2_DAC_EN_BIT       7  // In 0x2B
`define OPN2_PAN_L_BIT        7  // In 0xB6
`define OPN2_PAN_R_BIT        6

// Clock division chain
`define OPN2_CEN_DIV          6   // cen pulses per slot
`define OPN2_SLOTS            24  // Slots per sample
`define OPN2_TIMER_B_PRESCALE 16  // Samples per timer B count
`define OPN2_BUSY_TICKS       32  // Slots with busy high
`define OPN2_DAC_SHIFT        7   // 9-bit DAC to 16-bit output

`endif

// ==== src/opn2_pkg.sv ====
`default_nettype none

package opn2_pkg;

    // One register write from the chip bus
    typedef struct packed {
        logic       valid;  // Single-cycle strobe
        logic [7:0] addr;   // Latched register address
        logic [7:0] data;
    } reg_write_t;

    // Control of one timer
    typedef struct packed {
        logic       run;       // Load bit, counter runs while high
        logic       irq_en;    // Overflow may set the flag
        logic       flag_clr;  // One-cycle pulse
        logic [9:0] reload;    // Timer B uses bits 7..0
    } timer_ctrl_t;

    // Channel 6 DAC setup
    typedef struct packed {
        logic       enable;
        logic       pan_left;
        logic       pan_right;
        logic [7:0] sample;  // Unsigned, 0x80 is silence
    } dac_cfg_t;

    // Timer flags as seen in the status byte
    typedef struct packed {
        logic flag_b;
        logic flag_a;
    } timer_status_t;

endpackage

`default_nettype wire

// ==== src/opn2_prescaler.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "opn2_consts.svh"

module opn2_prescaler (
    input  logic clk,
    input  logic arst_n,
    input  logic cen,
    output logic clk_en,
    output logic sample_tick
);

    localparam int DIV_W  = $clog2(`OPN2_CEN_DIV);
    localparam int SLOT_W = $clog2(`OPN2_SLOTS);

    logic [DIV_W-1:0]  div_cnt;
    logic [SLOT_W-1:0] slot_cnt;  // Operator slot within the sample

    assign clk_en      = cen && (div_cnt == DIV_W'(`OPN2_CEN_DIV - 1));
    assign sample_tick = clk_en && (slot_cnt == SLOT_W'(`OPN2_SLOTS - 1));

    // Divide cen down to the slot rate
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt <= '0;
        end else if (cen) begin
            div_cnt <= clk_en ? '0 : div_cnt + 1'b1;
        end
    end

    // Count slots, wrap at the sample boundary
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            slot_cnt <= '0;
        end else if (clk_en) begin
            slot_cnt <= sample_tick ? '0 : slot_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== src/opn2_bus_if.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "opn2_consts.svh"

module opn2_bus_if (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    clk_en,
    input  logic                    cs_n,
    input  logic                    wr_n,
    input  logic [1:0]              addr,
    input  logic [7:0]              din,
    input  opn2_pkg::timer_status_t flags,
    output opn2_pkg::reg_write_t    reg_wr,
    output logic [7:0]              dout,
    output logic                    irq_n
);

    localparam int BUSY_W = $clog2(`OPN2_BUSY_TICKS + 1);

    logic              write;
    logic              addr_wr;   // Address port write
    logic              data_wr;   // Data port write
    logic [7:0]        reg_addr;  // Latched register address
    logic              wr_valid;
    logic [7:0]        wr_addr;
    logic [7:0]        wr_data;
    logic [BUSY_W-1:0] busy_cnt;
    logic              busy;

    assign write   = !cs_n && !wr_n;
    assign addr_wr = write && (addr == 2'd0);
    assign data_wr = write && (addr == 2'd1);  // Part II ports fall through

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            reg_addr <= '0;
            wr_valid <= 1'b0;
        end else begin
            wr_valid <= data_wr;
            if (addr_wr) reg_addr <= din;
        end
    end

    // Write payload
    always_ff @(posedge clk) begin
        if (data_wr) begin
            wr_addr <= reg_addr;
            wr_data <= din;
        end
    end

    assign reg_wr = '{valid: wr_valid, addr: wr_addr, data: wr_data};

    // Busy counts down in slots, restarted by every data write
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_cnt <= '0;
        end else if (data_wr) begin
            busy_cnt <= BUSY_W'(`OPN2_BUSY_TICKS);
        end else if (clk_en && busy) begin
            busy_cnt <= busy_cnt - 1'b1;
        end
    end

    assign busy  = (busy_cnt != '0);
    assign dout  = {busy, 5'd0, flags.flag_b, flags.flag_a};
    assign irq_n = !(flags.flag_a || flags.flag_b);

endmodule

`default_nettype wire

// ==== src/opn2_regs.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "opn2_consts.svh"

module opn2_regs (
    input  logic                  clk,
    input  logic                  arst_n,
    input  opn2_pkg::reg_write_t  reg_wr,
    output opn2_pkg::timer_ctrl_t timer_a,
    output opn2_pkg::timer_ctrl_t timer_b,
    output opn2_pkg::dac_cfg_t    dac
);

    logic [9:0] value_a;
    logic [7:0] value_b;
    logic       load_a;
    logic       load_b;
    logic       en_a;    // Flag A enable
    logic       en_b;
    logic       clr_a;   // Flag reset pulses
    logic       clr_b;
    logic       dac_en;
    logic       pan_l;
    logic       pan_r;
    logic [7:0] dac_sample;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            value_a    <= '0;
            value_b    <= '0;
            load_a     <= 1'b0;
            load_b     <= 1'b0;
            en_a       <= 1'b0;
            en_b       <= 1'b0;
            clr_a      <= 1'b0;
            clr_b      <= 1'b0;
            dac_en     <= 1'b0;
            pan_l      <= 1'b1;  // Both sides on, as the chip powers up
            pan_r      <= 1'b1;
            dac_sample <= '0;
        end else begin
            clr_a <= 1'b0;
            clr_b <= 1'b0;
            if (reg_wr.valid) begin
                case (reg_wr.addr)
                    `OPN2_REG_TIMER_A_HI: value_a[9:2] <= reg_wr.data;
                    `OPN2_REG_TIMER_A_LO: value_a[1:0] <= reg_wr.data[1:0];
                    `OPN2_REG_TIMER_B:    value_b      <= reg_wr.data;
                    `OPN2_REG_TIMER_CTRL: begin
                        load_a <= reg_wr.data[`OPN2_CTRL_LOAD_A];
                        load_b <= reg_wr.data[`OPN2_CTRL_LOAD_B];
                        en_a   <= reg_wr.data[`OPN2_CTRL_EN_A];
                        en_b   <= reg_wr.data[`OPN2_CTRL_EN_B];
                        clr_a  <= reg_wr.data[`OPN2_CTRL_RST_A];  // Not stored
                        clr_b  <= reg_wr.data[`OPN2_CTRL_RST_B];
                    end
                    `OPN2_REG_DAC_DATA: dac_sample <= reg_wr.data;
                    `OPN2_REG_DAC_EN:   dac_en     <= reg_wr.data[`OPN2_DAC_EN_BIT];
                    `OPN2_REG_CH6_PAN: begin
                        pan_l <= reg_wr.data[`OPN2_PAN_L_BIT];
                        pan_r <= reg_wr.data[`OPN2_PAN_R_BIT];
                    end
                    default: ;  // FM registers have no effect here
                endcase
            end
        end
    end

    assign timer_a = '{run: load_a, irq_en: en_a, flag_clr: clr_a, reload: value_a};
    assign timer_b = '{run: load_b, irq_en: en_b, flag_clr: clr_b,
                       reload: {2'b00, value_b}};
    assign dac     = '{enable: dac_en, pan_left: pan_l, pan_right: pan_r,
                       sample: dac_sample};

endmodule

`default_nettype wire

// ==== src/opn2_timer.sv ====
`default_nettype none
`timescale 1ns/1ps

module opn2_timer #(
    parameter int WIDTH    = 10,
    parameter int PRESCALE = 1
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  sample_tick,
    input  opn2_pkg::timer_ctrl_t ctrl,
    output logic                  flag
);

    localparam int PRE_W = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;

    logic [WIDTH-1:0] cnt;
    logic [PRE_W-1:0] pre_cnt;   // Samples within one count
    logic             run_q;
    logic             start;     // Rise of the load bit
    logic             count_en;
    logic             overflow;

    assign start    = ctrl.run && !run_q;
    assign count_en = ctrl.run && sample_tick && (pre_cnt == PRE_W'(PRESCALE - 1));
    assign overflow = count_en && !start && (cnt == '1);

    // Up counter, reloads on start and on overflow
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            run_q   <= 1'b0;
            cnt     <= '0;
            pre_cnt <= '0;
        end else begin
            run_q <= ctrl.run;
            if (start) begin
                cnt     <= ctrl.reload[WIDTH-1:0];
                pre_cnt <= '0;
            end else if (ctrl.run && sample_tick) begin
                pre_cnt <= count_en ? '0 : pre_cnt + 1'b1;
                if (overflow)
                    cnt <= ctrl.reload[WIDTH-1:0];
                else if (count_en)
                    cnt <= cnt + 1'b1;
            end
        end
    end

    // Flag holds until cleared, a new overflow wins
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flag <= 1'b0;
        end else if (overflow && ctrl.irq_en) begin
            flag <= 1'b1;
        end else if (ctrl.flag_clr) begin
            flag <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== src/opn2_pcm_dac.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "opn2_consts.svh"

module opn2_pcm_dac (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               sample_tick,
    input  opn2_pkg::dac_cfg_t dac,
    output logic signed [15:0] snd_left,
    output logic signed [15:0] snd_right,
    output logic               snd_sample
);

    logic signed [8:0]  pcm9;   // Sample with the 0x80 offset removed
    logic signed [15:0] pcm16;
    logic               left_on;
    logic               right_on;

    assign pcm9     = signed'({1'b0, dac.sample} - 9'd128);
    assign pcm16    = {pcm9, {`OPN2_DAC_SHIFT{1'b0}}};
    assign left_on  = dac.enable && dac.pan_left;
    assign right_on = dac.enable && dac.pan_right;

    // Outputs move only on the sample boundary
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            snd_left   <= '0;
            snd_right  <= '0;
            snd_sample <= 1'b0;
        end else begin
            snd_sample <= sample_tick;
            if (sample_tick) begin
                snd_left  <= left_on  ? pcm16 : 16'sd0;
                snd_right <= right_on ? pcm16 : 16'sd0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/opn2_top.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "opn2_consts.svh"

module opn2_top (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               cen,      // Tie high if unused
    input  logic [7:0]         din,
    input  logic [1:0]         addr,
    input  logic               cs_n,
    input  logic               wr_n,
    output logic [7:0]         dout,     // Status byte
    output logic               irq_n,
    output logic signed [15:0] snd_left,
    output logic signed [15:0] snd_right,
    output logic               snd_sample
);

    import opn2_pkg::*;

    logic          clk_en;
    logic          sample_tick;
    reg_write_t    reg_wr;
    timer_ctrl_t   timer_a_ctrl;
    timer_ctrl_t   timer_b_ctrl;
    dac_cfg_t      dac_cfg;
    logic          flag_a;
    logic          flag_b;
    timer_status_t flags;

    assign flags = '{flag_b: flag_b, flag_a: flag_a};

    opn2_prescaler u_prescaler (
        .clk         (clk),
        .arst_n      (arst_n),
        .cen         (cen),
        .clk_en      (clk_en),
        .sample_tick (sample_tick)
    );

    opn2_bus_if u_bus_if (
        .clk    (clk),
        .arst_n (arst_n),
        .clk_en (clk_en),
        .cs_n   (cs_n),
        .wr_n   (wr_n),
        .addr   (addr),
        .din    (din),
        .flags  (flags),
        .reg_wr (reg_wr),
        .dout   (dout),
        .irq_n  (irq_n)
    );

    opn2_regs u_regs (
        .clk     (clk),
        .arst_n  (arst_n),
        .reg_wr  (reg_wr),
        .timer_a (timer_a_ctrl),
        .timer_b (timer_b_ctrl),
        .dac     (dac_cfg)
    );

    // Timer A counts every sample
    opn2_timer #(.WIDTH(10), .PRESCALE(1)) u_timer_a (
        .clk         (clk),
        .arst_n      (arst_n),
        .sample_tick (sample_tick),
        .ctrl        (timer_a_ctrl),
        .flag        (flag_a)
    );

    opn2_timer #(.WIDTH(8), .PRESCALE(`OPN2_TIMER_B_PRESCALE)) u_timer_b (
        .clk         (clk),
        .arst_n      (arst_n),
        .sample_tick (sample_tick),
        .ctrl        (timer_b_ctrl),
        .flag        (flag_b)
    );

    opn2_pcm_dac u_pcm_dac (
        .clk         (clk),
        .arst_n      (arst_n),
        .sample_tick (sample_tick),
        .dac         (dac_cfg),
        .snd_left    (snd_left),
        .snd_right   (snd_right),
        .snd_sample  (snd_sample)
    );

endmodule

`default_nettype wire

// ==== tb/opn2_checker.sv ====
`default_nettype none
`timescale 1ns/1ps

module opn2_checker (
    input  logic        clk,
    input  logic [7:0]  dout,
    input  logic        irq_n,
    input  logic [15:0] snd_left,
    input  logic [15:0] snd_right,
    input  logic        mark,       // Last write of a row, time origin for events
    input  logic        check,
    input  logic        timed_out,
    input  logic        done,
    input  int          test_id,
    input  logic [7:0]  exp_dout,
    input  logic        exp_irq_n,
    input  logic [15:0] exp_left,
    input  logic [15:0] exp_right,
    input  int          t_min,
    input  int          t_max,      // Zero for an untimed row
    output int          tests,
    output int          fails
);

    int cyc;
    int t_mark;
    int elapsed;
    bit ok;

    task automatic compare(input string sig, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("FAIL test %0d: %s is 0x%0h, expected 0x%0h", test_id, sig, got, exp);
            ok = 1'b0;
        end
    endtask

    initial begin
        cyc    = 0;
        t_mark = 0;
        tests  = 0;
        fails  = 0;
    end

    // Outputs are read here, half a cycle after the stimulus moved
    always @(posedge clk) begin
        cyc = cyc + 1;
        if (mark) t_mark = cyc;
        if (check) begin
            ok      = 1'b1;
            elapsed = cyc - t_mark;
            if (timed_out) begin
                $display("test %0d: the DUT event never came", test_id);
                ok = 1'b0;
            end else begin
                compare("dout", 16'(dout), 16'(exp_dout));
                compare("irq_n", 16'(irq_n), 16'(exp_irq_n));
                compare("snd_left", snd_left, exp_left);
                compare("snd_right", snd_right, exp_right);
                if (t_max != 0 && (elapsed < t_min || elapsed > t_max)) begin
                    $display("test %0d: event came %0d cycles after the write, not %0d to %0d",
                             test_id, elapsed, t_min, t_max);
                    ok = 1'b0;
                end
            end
            tests = tests + 1;
            if (!ok) fails = fails + 1;
            $display("test %0d %s, %0d cycles", test_id, ok ? "ok" : "failed", elapsed);
        end
        if (done) $display("checks run: %0d, failed: %0d", tests, fails);
    end

endmodule

`default_nettype wire

// ==== tb/opn2_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "opn2_consts.svh"

module opn2_tb;

    localparam int CLK_PERIOD = 100;
    localparam int SAMPLE_CYC = `OPN2_CEN_DIV * `OPN2_SLOTS;  // Clocks per sample
    localparam int BUSY_CYC   = `OPN2_BUSY_TICKS * `OPN2_CEN_DIV;
    localparam int TA_LOAD    = 1020;
    localparam int TB_LOAD    = 255;
    localparam int TA_SAMPLES = 1024 - TA_LOAD;
    localparam int TB_SAMPLES = `OPN2_TIMER_B_PRESCALE * (256 - TB_LOAD);

    localparam logic [7:0] LOAD_A = 8'(1 << `OPN2_CTRL_LOAD_A);
    localparam logic [7:0] LOAD_B = 8'(1 << `OPN2_CTRL_LOAD_B);
    localparam logic [7:0] EN_A   = 8'(1 << `OPN2_CTRL_EN_A);
    localparam logic [7:0] EN_B   = 8'(1 << `OPN2_CTRL_EN_B);
    localparam logic [7:0] RST_A  = 8'(1 << `OPN2_CTRL_RST_A);
    localparam logic [7:0] RST_B  = 8'(1 << `OPN2_CTRL_RST_B);

    localparam int EVT_NONE     = 0;
    localparam int EVT_BUSY_LOW = 1;
    localparam int EVT_IRQ_LOW  = 2;
    localparam int EVT_SAMPLE   = 3;

    typedef struct packed {
        int          pre;       // Cycles to wait after the writes
        int          evt;
        int          t_min;     // Event window from the last write
        int          t_max;
        int          wr_first;
        int          wr_count;
        logic [7:0]  exp_dout;
        logic        exp_irq_n;
        logic [15:0] exp_left;
        logic [15:0] exp_right;
    } row_t;

    logic clk;
    logic arst_n;
    logic cen;
    logic [7:0] din;
    logic [1:0] addr;
    logic cs_n;
    logic wr_n;
    logic [7:0] dout;
    logic irq_n;
    logic signed [15:0] snd_left;
    logic signed [15:0] snd_right;
    logic snd_sample;

    logic mark;
    logic check;
    logic timed_out;
    logic done;
    int test_id;
    logic [7:0] exp_dout;
    logic exp_irq_n;
    logic [15:0] exp_left;
    logic [15:0] exp_right;
    int t_min;
    int t_max;
    int tests;
    int fails;

    row_t rows[$];
    logic [9:0] wr_q[$];  // Port and data byte
    int row_start;
    logic [31:0] rng;
    int wd_cycles;
    logic table_ready;

    opn2_top opn2_top_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .cen        (cen),
        .din        (din),
        .addr       (addr),
        .cs_n       (cs_n),
        .wr_n       (wr_n),
        .dout       (dout),
        .irq_n      (irq_n),
        .snd_left   (snd_left),
        .snd_right  (snd_right),
        .snd_sample (snd_sample)
    );

    opn2_checker u_checker (
        .clk       (clk),
        .dout      (dout),
        .irq_n     (irq_n),
        .snd_left  (snd_left),
        .snd_right (snd_right),
        .mark      (mark),
        .check     (check),
        .timed_out (timed_out),
        .done      (done),
        .test_id   (test_id),
        .exp_dout  (exp_dout),
        .exp_irq_n (exp_irq_n),
        .exp_left  (exp_left),
        .exp_right (exp_right),
        .t_min     (t_min),
        .t_max     (t_max),
        .tests     (tests),
        .fails     (fails)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Offset binary to signed, then up to 16 bits
    function automatic logic [15:0] dac_level(input logic [7:0] s);
        int centered;
        centered = int'(s) - 128;
        return 16'(centered <<< `OPN2_DAC_SHIFT);
    endfunction

    function automatic logic event_seen(input int evt);
        case (evt)
            EVT_BUSY_LOW: return !dout[7];
            EVT_IRQ_LOW:  return !irq_n;
            EVT_SAMPLE:   return snd_sample;
            default:      return 1'b1;
        endcase
    endfunction

    task automatic bus_write(input logic [1:0] port, input logic [7:0] data);
        wr_q.push_back({port, data});
    endtask

    task automatic reg_write(input logic [7:0] reg_addr, input logic [7:0] data);
        bus_write(2'd0, reg_addr);
        bus_write(2'd1, data);
    endtask

    task automatic add_row(input int pre, input int evt, input int lo, input int hi,
                           input logic [7:0] dout_e, input logic irq_e,
                           input logic [15:0] left_e, input logic [15:0] right_e);
        row_t r;
        r = '{pre, evt, lo, hi, row_start, wr_q.size() - row_start,
              dout_e, irq_e, left_e, right_e};
        rows.push_back(r);
        row_start = wr_q.size();
    endtask

    task automatic build_table();
        logic [7:0] pan;
        logic [15:0] lvl;
        add_row(0, EVT_SAMPLE, SAMPLE_CYC - 4, SAMPLE_CYC + 6, 8'h00, 1'b1, 16'h0, 16'h0);
        reg_write(`OPN2_REG_DAC_DATA, 8'h80);
        add_row(0, EVT_NONE, 0, 0, 8'h80, 1'b1, 16'h0, 16'h0);
        add_row(0, EVT_BUSY_LOW, BUSY_CYC - `OPN2_CEN_DIV, BUSY_CYC + 2 * `OPN2_CEN_DIV,
                8'h00, 1'b1, 16'h0, 16'h0);
        reg_write(`OPN2_REG_TIMER_A_HI, 8'(TA_LOAD >> 2));
        reg_write(`OPN2_REG_TIMER_A_LO, 8'(TA_LOAD & 3));
        reg_write(`OPN2_REG_TIMER_CTRL, LOAD_A | EN_A);
        add_row(0, EVT_IRQ_LOW, (TA_SAMPLES - 1) * SAMPLE_CYC, TA_SAMPLES * SAMPLE_CYC + 8,
                8'h01, 1'b0, 16'h0, 16'h0);
        reg_write(`OPN2_REG_TIMER_CTRL, LOAD_A | EN_A | RST_A);
        add_row(4, EVT_NONE, 0, 0, 8'h80, 1'b1, 16'h0, 16'h0);
        reg_write(`OPN2_REG_TIMER_CTRL, LOAD_A | RST_A);  // Keeps counting, flag masked
        add_row((TA_SAMPLES + 1) * SAMPLE_CYC, EVT_NONE, 0, 0, 8'h00, 1'b1, 16'h0, 16'h0);
        reg_write(`OPN2_REG_TIMER_B, 8'(TB_LOAD));
        reg_write(`OPN2_REG_TIMER_CTRL, LOAD_B | EN_B);
        add_row(0, EVT_IRQ_LOW, (TB_SAMPLES - 1) * SAMPLE_CYC, TB_SAMPLES * SAMPLE_CYC + 8,
                8'h02, 1'b0, 16'h0, 16'h0);
        reg_write(`OPN2_REG_TIMER_CTRL, RST_B);
        add_row(4, EVT_NONE, 0, 0, 8'h80, 1'b1, 16'h0, 16'h0);
        reg_write(`OPN2_REG_DAC_EN, 8'h80);
        for (int i = 0; i < 3; i++) begin
            pan = (i == 0) ? 8'hC0 : (i == 1) ? 8'h80 : 8'h40;  // Both, left, right
            rng = xorshift(rng);
            lvl = dac_level(rng[7:0]);
            reg_write(`OPN2_REG_CH6_PAN, pan);
            reg_write(`OPN2_REG_DAC_DATA, rng[7:0]);
            add_row(4, EVT_SAMPLE, 4, SAMPLE_CYC + 8, 8'h80, 1'b1,
                    pan[7] ? lvl : 16'h0, pan[6] ? lvl : 16'h0);
        end
        reg_write(`OPN2_REG_DAC_EN, 8'h00);
        add_row(4, EVT_SAMPLE, 4, SAMPLE_CYC + 8, 8'h80, 1'b1, 16'h0, 16'h0);
        add_row(0, EVT_BUSY_LOW, BUSY_CYC - `OPN2_CEN_DIV, BUSY_CYC + 2 * `OPN2_CEN_DIV,
                8'h00, 1'b1, 16'h0, 16'h0);
        // Part II ports must not reach the registers or start busy
        bus_write(2'd2, `OPN2_REG_DAC_EN);
        bus_write(2'd3, 8'h80);
        add_row(4, EVT_SAMPLE, 4, SAMPLE_CYC + 8, 8'h00, 1'b1, 16'h0, 16'h0);
        bus_write(2'd2, `OPN2_REG_TIMER_CTRL);
        bus_write(2'd3, LOAD_A | LOAD_B | EN_A | EN_B);
        add_row((TA_SAMPLES + 1) * SAMPLE_CYC, EVT_NONE, 0, 0, 8'h00, 1'b1, 16'h0, 16'h0);
    endtask

    task automatic apply_row(input int idx);
        row_t r;
        logic [9:0] w;
        int waited;
        r = rows[idx];
        for (int i = 0; i < r.wr_count; i++) begin
            w    = wr_q[r.wr_first + i];
            cs_n = 1'b0;
            wr_n = 1'b0;
            addr = w[9:8];
            din  = w[7:0];
            mark = (i == r.wr_count - 1);
            @(negedge clk);
        end
        cs_n = 1'b1;
        wr_n = 1'b1;
        mark = 1'b0;
        repeat (r.pre) @(negedge clk);
        waited = r.pre;
        while (r.evt != EVT_NONE && !event_seen(r.evt) && waited < r.t_max + 10) begin
            @(negedge clk);
            waited++;
        end
        test_id   = idx;
        exp_dout  = r.exp_dout;
        exp_irq_n = r.exp_irq_n;
        exp_left  = r.exp_left;
        exp_right = r.exp_right;
        t_min     = r.t_min;
        t_max     = r.t_max;
        timed_out = (r.evt != EVT_NONE) && !event_seen(r.evt);
        check     = 1'b1;
        @(negedge clk);
        check     = 1'b0;
        timed_out = 1'b0;
    endtask

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        cen         = 1'b1;
        din         = 8'h00;
        addr        = 2'd0;
        cs_n        = 1'b1;
        wr_n        = 1'b1;
        mark        = 1'b0;
        check       = 1'b0;
        timed_out   = 1'b0;
        done        = 1'b0;
        test_id     = 0;
        exp_dout    = 8'h00;
        exp_irq_n   = 1'b1;
        exp_left    = 16'h0;
        exp_right   = 16'h0;
        t_min       = 0;
        t_max       = 0;
        row_start   = 0;
        rng         = 32'h6a25b5a3;
        table_ready = 1'b0;
        build_table();
        wd_cycles = 200;
        foreach (rows[i]) wd_cycles += rows[i].pre + rows[i].t_max + rows[i].wr_count + 12;
        table_ready = 1'b1;
        repeat (2) @(negedge clk);
        arst_n = 1'b1;
        mark   = 1'b1;  // Reset release starts the first window
        @(negedge clk);
        mark   = 1'b0;
        foreach (rows[i]) apply_row(i);
        done = 1'b1;
        @(posedge clk);
        #1;
        if (fails == 0 && tests == rows.size())
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

    initial begin
        wait (table_ready);
        #(wd_cycles * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the table did not finish", wd_cycles);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== opn2_top.f ====
+incdir+src
src/opn2_pkg.sv
src/opn2_prescaler.sv
src/opn2_bus_if.sv
src/opn2_regs.sv
src/opn2_timer.sv
src/opn2_pcm_dac.sv
src/opn2_top.sv
tb/opn2_checker.sv
tb/opn2_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = opn2_tb
FILELIST  = opn2_top.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = TESTS FAILED

SOURCES = $(wildcard src/*.sv src/*.svh tb/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TESTS PASSED" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
